// File: src/video_pkg.sv
package video_pkg;

   // word address layout, msb first:
   // 6 zero bits, frame selector, line, beat in line, 1 zero bit
   localparam int FRAME_SEL_W = 6;
   localparam int LINE_W      = 10;
   localparam int BEAT_W      = 8;
   localparam int ADDR_W      = 31;
   localparam int BEAT_BITS   = 128;

   // ddr command opcode
   typedef enum logic {
      MEM_WRITE = 1'b0,
      MEM_READ  = 1'b1
   } mem_op_t;

   // one command on the shared ddr port, 160 bits
   typedef struct packed {
      mem_op_t                opcode;
      logic [ADDR_W-1:0]      addr;
      logic [BEAT_BITS-1:0]   wdata;
   } mem_cmd_t;

   // pixel feeder fetch fsm
   typedef enum logic {
      FEED_IDLE  = 1'b0,
      FEED_FETCH = 1'b1
   } feeder_state_t;

   // fill engine fsm
   typedef enum logic [1:0] {
      FILL_IDLE = 2'd0,
      FILL_RUN  = 2'd1,
      FILL_DONE = 2'd2
   } fill_state_t;

   // common address rule for both masters
   function automatic logic [ADDR_W-1:0] make_addr(
      input logic [FRAME_SEL_W-1:0] frame,
      input logic [LINE_W-1:0]      line,
      input logic [BEAT_W-1:0]      beat
   );
      return {6'b0, frame, line, beat, 1'b0};
   endfunction

endpackage

// File: src/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo #(
   parameter int FIFO_BEATS = 16
) (
   input  logic         cpu_clk_g,
   input  logic         rst,
   input  logic [127:0] din,
   input  logic         wr_en,
   input  logic         rd_en,
   output logic [31:0]  dout,
   output logic         empty,
   output logic         beat_done
);

   localparam int PTR_W = (FIFO_BEATS > 1) ? $clog2(FIFO_BEATS) : 1;
   localparam int CNT_W = $clog2(FIFO_BEATS + 1);

   // beat storage, no reset needed
   logic [127:0]     mem [FIFO_BEATS];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // beats held, occupancy
   logic [CNT_W-1:0] count;
   // pixel lane within the head beat
   logic [1:0]       pix_idx;

   // lane 0 is the first pixel of a beat
   assign dout      = mem[rd_ptr][pix_idx*32 +: 32];
   assign empty     = (count == '0);
   // fourth pop retires the head beat
   assign beat_done = rd_en && (pix_idx == 2'd3);

   always_ff @(posedge cpu_clk_g) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         pix_idx <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_BEATS - 1)) ? '0 : wr_ptr + PTR_W'(1);
         end
         if (rd_en) begin
            pix_idx <= pix_idx + 2'd1;
         end
         if (beat_done) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_BEATS - 1)) ? '0 : rd_ptr + PTR_W'(1);
         end
         count <= count + CNT_W'(wr_en) - CNT_W'(beat_done);
      end
   end

   // feeder credits must keep the buffer from overflowing
   a_no_overflow: assert property (@(posedge cpu_clk_g) disable iff (rst)
      !(wr_en && (count == CNT_W'(FIFO_BEATS))))
      else $error("pixel fifo written while full");

   // display side only pops when valid
   a_no_underflow: assert property (@(posedge cpu_clk_g) disable iff (rst)
      !(rd_en && empty))
      else $error("pixel fifo popped while empty");

endmodule

// File: src/pixel_feeder.sv
`timescale 1ns/1ps

module pixel_feeder #(
   parameter int H_PIXELS   = 800,
   parameter int V_LINES    = 600,
   parameter int FIFO_BEATS = 16
) (
   input  logic                 cpu_clk_g,
   input  logic                 rst,
   // command side, to the arbiter
   output logic                 cmd_req,
   output video_pkg::mem_cmd_t  cmd,
   input  logic                 cmd_grant,
   // read return
   input  logic                 rdf_valid,
   input  logic [127:0]         rdf_dout,
   // display sink
   output logic [23:0]          video,
   output logic                 video_valid,
   input  logic                 video_ready,
   // frame swap control
   input  logic [5:0]           gp_frame,
   input  logic                 gp_trigger,
   output logic                 frame_interrupt
);

   localparam int BW       = video_pkg::BEAT_W;
   localparam int LW       = video_pkg::LINE_W;
   localparam int CREDIT_W = $clog2(FIFO_BEATS + 1);

   video_pkg::feeder_state_t state;
   video_pkg::feeder_state_t state_nxt;

   // beats asked for or still in the fifo
   logic [CREDIT_W-1:0] credit;
   logic [CREDIT_W-1:0] credit_nxt;
   // fetch position
   logic [BW-1:0]       beat_cnt;
   logic [LW-1:0]       line_cnt;
   logic                last_beat;
   logic                last_line;
   logic                fetch_wrap;
   // displayed frame and pending swap
   logic [5:0]          disp_frame;
   logic [5:0]          swap_frame;
   logic                swap_pend;
   // fifo hookup
   logic [31:0]         fifo_dout;
   logic                fifo_empty;
   logic                pix_pop;
   logic                beat_done;

   assign last_beat  = (beat_cnt == BW'(H_PIXELS / 4 - 1));
   assign last_line  = (line_cnt == LW'(V_LINES - 1));
   // last beat of last line granted
   assign fetch_wrap = cmd_grant && last_beat && last_line;

   // up on each grant, down when a whole beat leaves the fifo
   assign credit_nxt = credit + CREDIT_W'(cmd_grant) - CREDIT_W'(beat_done);

   always_comb begin
      state_nxt = state;
      case (state)
         video_pkg::FEED_IDLE: begin
            if (credit_nxt < CREDIT_W'(FIFO_BEATS)) begin
               state_nxt = video_pkg::FEED_FETCH;
            end
         end
         video_pkg::FEED_FETCH: begin
            if (credit_nxt == CREDIT_W'(FIFO_BEATS)) begin
               state_nxt = video_pkg::FEED_IDLE;
            end
         end
         default: state_nxt = video_pkg::FEED_IDLE;
      endcase
   end

   // request held until granted, address only moves on grant
   assign cmd_req = (state == video_pkg::FEED_FETCH);

   always_comb begin
      cmd.opcode = video_pkg::MEM_READ;
      cmd.addr   = video_pkg::make_addr(disp_frame, line_cnt, beat_cnt);
      cmd.wdata  = '0;
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         state           <= video_pkg::FEED_IDLE;
         credit          <= '0;
         beat_cnt        <= '0;
         line_cnt        <= '0;
         disp_frame      <= 6'd1;
         swap_pend       <= 1'b0;
         frame_interrupt <= 1'b0;
      end else begin
         state           <= state_nxt;
         credit          <= credit_nxt;
         frame_interrupt <= fetch_wrap;
         if (cmd_grant) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + BW'(1);
            if (last_beat) begin
               line_cnt <= last_line ? '0 : line_cnt + LW'(1);
            end
         end
         // swap takes effect where the next frame fetch starts
         if (fetch_wrap && swap_pend) begin
            disp_frame <= swap_frame;
            swap_pend  <= 1'b0;
         end
         // a fresh trigger wins over the clear above
         if (gp_trigger) begin
            swap_pend <= 1'b1;
         end
      end
   end

   // requested frame, only used once pending
   always_ff @(posedge cpu_clk_g) begin
      if (gp_trigger) begin
         swap_frame <= gp_frame;
      end
   end

   assign pix_pop     = video_valid && video_ready;
   assign video_valid = !fifo_empty;
   // low 24 bits carry rgb
   assign video       = fifo_dout[23:0];

   pixel_fifo #(
      .FIFO_BEATS (FIFO_BEATS)
   ) pixel_fifo_i (
      .cpu_clk_g (cpu_clk_g),
      .rst       (rst),
      .din       (rdf_dout),
      .wr_en     (rdf_valid),
      .rd_en     (pix_pop),
      .dout      (fifo_dout),
      .empty     (fifo_empty),
      .beat_done (beat_done)
   );

   a_credit_max: assert property (@(posedge cpu_clk_g) disable iff (rst)
      credit <= CREDIT_W'(FIFO_BEATS))
      else $error("feeder credit above fifo depth");

endmodule

// File: src/fill_engine.sv
`timescale 1ns/1ps

module fill_engine #(
   parameter int H_PIXELS = 800,
   parameter int V_LINES  = 600
) (
   input  logic                 cpu_clk_g,
   input  logic                 rst,
   input  logic                 fill_start,
   input  logic [5:0]           fill_frame,
   input  logic [23:0]          fill_color,
   output logic                 cmd_req,
   output video_pkg::mem_cmd_t  cmd,
   input  logic                 cmd_grant,
   output logic                 fill_done
);

   localparam int BW = video_pkg::BEAT_W;
   localparam int LW = video_pkg::LINE_W;

   video_pkg::fill_state_t state;

   // latched job
   logic [5:0]    frame_q;
   logic [23:0]   color_q;
   // write position
   logic [BW-1:0] beat_cnt;
   logic [LW-1:0] line_cnt;
   logic          last_beat;
   logic          last_line;

   assign last_beat = (beat_cnt == BW'(H_PIXELS / 4 - 1));
   assign last_line = (line_cnt == LW'(V_LINES - 1));

   assign cmd_req   = (state == video_pkg::FILL_RUN);
   // done state lasts one cycle, right after the final grant
   assign fill_done = (state == video_pkg::FILL_DONE);

   always_comb begin
      cmd.opcode = video_pkg::MEM_WRITE;
      cmd.addr   = video_pkg::make_addr(frame_q, line_cnt, beat_cnt);
      // four pixels per beat, colour zero extended
      cmd.wdata  = {4{8'h00, color_q}};
   end

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         state    <= video_pkg::FILL_IDLE;
         beat_cnt <= '0;
         line_cnt <= '0;
      end else begin
         case (state)
            video_pkg::FILL_IDLE: begin
               // start only honoured when idle
               if (fill_start) begin
                  beat_cnt <= '0;
                  line_cnt <= '0;
                  state    <= video_pkg::FILL_RUN;
               end
            end
            video_pkg::FILL_RUN: begin
               if (cmd_grant) begin
                  beat_cnt <= last_beat ? '0 : beat_cnt + BW'(1);
                  if (last_beat) begin
                     line_cnt <= last_line ? '0 : line_cnt + LW'(1);
                     if (last_line) begin
                        state <= video_pkg::FILL_DONE;
                     end
                  end
               end
            end
            default: state <= video_pkg::FILL_IDLE;
         endcase
      end
   end

   // job payload, captured at start
   always_ff @(posedge cpu_clk_g) begin
      if (fill_start && (state == video_pkg::FILL_IDLE)) begin
         frame_q <= fill_frame;
         color_q <= fill_color;
      end
   end

endmodule

// File: src/frame_mem_arbiter.sv
`timescale 1ns/1ps

module frame_mem_arbiter (
   input  logic                 cpu_clk_g,
   input  logic                 rst,
   // pixel feeder
   input  logic                 feed_req,
   input  video_pkg::mem_cmd_t  feed_cmd,
   output logic                 feed_grant,
   // fill engine
   input  logic                 fill_req,
   input  video_pkg::mem_cmd_t  fill_cmd,
   output logic                 fill_grant,
   // ddr command port
   input  logic                 af_full,
   output logic                 af_wr_en,
   output video_pkg::mem_cmd_t  af_cmd
);

   // fill engine had the last grant
   logic last_fill;
   logic pick_fill;

   // fill wins if alone, or if feeder went last
   assign pick_fill  = fill_req && (!feed_req || !last_fill);

   // grants are same-cycle, blocked by a full command fifo
   assign fill_grant = !af_full && pick_fill;
   assign feed_grant = !af_full && feed_req && !pick_fill;
   assign af_wr_en   = feed_grant || fill_grant;
   assign af_cmd     = pick_fill ? fill_cmd : feed_cmd;

   always_ff @(posedge cpu_clk_g) begin
      if (rst) begin
         last_fill <= 1'b0;
      end else if (af_wr_en) begin
         last_fill <= fill_grant;
      end
   end

   a_one_grant: assert property (@(posedge cpu_clk_g) disable iff (rst)
      !(feed_grant && fill_grant))
      else $error("both masters granted");

endmodule

// File: src/video_subsystem.sv
`timescale 1ns/1ps

module video_subsystem #(
   parameter int H_PIXELS   = 800,
   parameter int V_LINES    = 600,
   parameter int FIFO_BEATS = 16
) (
   input  logic               cpu_clk_g,
   input  logic               rst,
   // ddr command and read data
   input  logic               af_full,
   output logic               af_wr_en,
   output video_pkg::mem_op_t af_op,
   output logic [30:0]        af_addr_din,
   output logic [127:0]       wdf_din,
   input  logic               rdf_valid,
   input  logic [127:0]       rdf_dout,
   output logic               rdf_rd_en,
   // display
   output logic [23:0]        video,
   output logic               video_valid,
   input  logic               video_ready,
   // control
   input  logic [5:0]         gp_frame,
   input  logic               gp_trigger,
   output logic               frame_interrupt,
   input  logic               fill_start,
   input  logic [5:0]         fill_frame,
   input  logic [23:0]        fill_color,
   output logic               fill_done
);

   video_pkg::mem_cmd_t feeder_cmd;
   video_pkg::mem_cmd_t fill_cmd;
   video_pkg::mem_cmd_t af_cmd;
   logic                feeder_req;
   logic                feeder_grant;
   logic                fill_req;
   logic                fill_grant;

   // read data always drained
   assign rdf_rd_en   = 1'b1;
   assign af_op       = af_cmd.opcode;
   assign af_addr_din = af_cmd.addr;
   assign wdf_din     = af_cmd.wdata;

   pixel_feeder #(
      .H_PIXELS   (H_PIXELS),
      .V_LINES    (V_LINES),
      .FIFO_BEATS (FIFO_BEATS)
   ) pixel_feeder_i (
      .cpu_clk_g       (cpu_clk_g),
      .rst             (rst),
      .cmd_req         (feeder_req),
      .cmd             (feeder_cmd),
      .cmd_grant       (feeder_grant),
      .rdf_valid       (rdf_valid),
      .rdf_dout        (rdf_dout),
      .video           (video),
      .video_valid     (video_valid),
      .video_ready     (video_ready),
      .gp_frame        (gp_frame),
      .gp_trigger      (gp_trigger),
      .frame_interrupt (frame_interrupt)
   );

   fill_engine #(
      .H_PIXELS (H_PIXELS),
      .V_LINES  (V_LINES)
   ) fill_engine_i (
      .cpu_clk_g  (cpu_clk_g),
      .rst        (rst),
      .fill_start (fill_start),
      .fill_frame (fill_frame),
      .fill_color (fill_color),
      .cmd_req    (fill_req),
      .cmd        (fill_cmd),
      .cmd_grant  (fill_grant),
      .fill_done  (fill_done)
   );

   frame_mem_arbiter frame_mem_arbiter_i (
      .cpu_clk_g  (cpu_clk_g),
      .rst        (rst),
      .feed_req   (feeder_req),
      .feed_cmd   (feeder_cmd),
      .feed_grant (feeder_grant),
      .fill_req   (fill_req),
      .fill_cmd   (fill_cmd),
      .fill_grant (fill_grant),
      .af_full    (af_full),
      .af_wr_en   (af_wr_en),
      .af_cmd     (af_cmd)
   );

endmodule

// File: testbench/ddr_model.sv
`timescale 1ns/1ps

module ddr_model (
   input  logic               cpu_clk_g,
   input  logic               rst,
   input  logic               af_wr_en,
   input  video_pkg::mem_op_t af_op,
   input  logic [30:0]        af_addr_din,
   input  logic [127:0]       wdf_din,
   output logic               af_full,
   output logic               rdf_valid,
   output logic [127:0]       rdf_dout
);

   integer       seed = 32'hb0f7_59d1;
   // written beats, newest at the back
   logic [30:0]  wr_addr_q [$];
   logic [127:0] wr_data_q [$];
   // pending read returns, kept in command order
   logic [127:0] rd_data_q [$];
   int           rd_due_q  [$];
   int           cyc      = 0;
   int           last_due = 0;

   // stored beat, or lane k = address + k where never written
   function automatic logic [127:0] read_word(input logic [30:0] addr);
      logic [127:0] word;
      for (int k = 0; k < 4; k++) begin
         word[k*32 +: 32] = 32'(addr) + 32'(k);
      end
      for (int i = 0; i < wr_addr_q.size(); i++) begin
         if (wr_addr_q[i] == addr) begin
            word = wr_data_q[i];
         end
      end
      return word;
   endfunction

   initial begin
      af_full   = 1'b0;
      rdf_valid = 1'b0;
      rdf_dout  = '0;
   end

   // accepted commands, settled by the falling edge
   always @(negedge cpu_clk_g) begin
      int due;
      if (!rst && af_wr_en) begin
         if (af_op == video_pkg::MEM_READ) begin
            // 1 to 4 cycles, never overtaking an older read
            due = cyc + 1 + int'($unsigned($random(seed)) % 4);
            if (due <= last_due) begin
               due = last_due + 1;
            end
            last_due = due;
            rd_data_q.push_back(read_word(af_addr_din));
            rd_due_q.push_back(due);
         end else begin
            wr_addr_q.push_back(af_addr_din);
            wr_data_q.push_back(wdf_din);
         end
      end
   end

   // outputs change shortly after the rising edge
   always @(posedge cpu_clk_g) begin
      #2;
      cyc       = cyc + 1;
      // full about one cycle in four
      af_full   = ($unsigned($random(seed)) % 4) == 0;
      rdf_valid = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
         rdf_valid = 1'b1;
         rdf_dout  = rd_data_q.pop_front();
         void'(rd_due_q.pop_front());
      end
   end

endmodule

// File: testbench/tb_video_subsystem.sv
`timescale 1ns/1ps

module tb_video_subsystem;

   localparam int H_PIXELS   = 16;
   localparam int V_LINES    = 4;
   localparam int FIFO_BEATS = 4;
   localparam int FRAME_PIX  = H_PIXELS * V_LINES;
   localparam int WAIT_LIMIT = 4000;
   localparam logic [23:0] FILL_COLOR = 24'h3a_c5_7e;

   logic               cpu_clk_g;
   logic               rst;
   logic               af_full;
   logic               af_wr_en;
   video_pkg::mem_op_t af_op;
   logic [30:0]        af_addr_din;
   logic [127:0]       wdf_din;
   logic               rdf_valid;
   logic [127:0]       rdf_dout;
   logic               rdf_rd_en;
   logic [23:0]        video;
   logic               video_valid;
   logic               video_ready;
   logic [5:0]         gp_frame;
   logic               gp_trigger;
   logic               frame_interrupt;
   logic               fill_start;
   logic [5:0]         fill_frame;
   logic [23:0]        fill_color;
   logic               fill_done;

   integer      seed = 32'hb0f7_59d1;
   logic        ready_random = 1'b0;
   // frames cleared so far and their colour
   bit          filled [64];
   logic [23:0] colour_of [64];
   // sink position and progress
   int          line_pos     = 0;
   int          col_pos      = 0;
   int          consumed     = 0;
   int          irq_count    = 0;
   int          frames_done  = 0;
   int          frame2_count = 0;
   // frame selector of each fetched frame, oldest first
   int          frame_seq [$];
   int          shown_frame  = 1;
   int          swap_frame_m = 1;
   logic        swap_pend_m  = 1'b0;
   logic        trig_prev    = 1'b0;

   video_subsystem #(
      .H_PIXELS   (H_PIXELS),
      .V_LINES    (V_LINES),
      .FIFO_BEATS (FIFO_BEATS)
   ) video_subsystem_i (
      .cpu_clk_g       (cpu_clk_g),
      .rst             (rst),
      .af_full         (af_full),
      .af_wr_en        (af_wr_en),
      .af_op           (af_op),
      .af_addr_din     (af_addr_din),
      .wdf_din         (wdf_din),
      .rdf_valid       (rdf_valid),
      .rdf_dout        (rdf_dout),
      .rdf_rd_en       (rdf_rd_en),
      .video           (video),
      .video_valid     (video_valid),
      .video_ready     (video_ready),
      .gp_frame        (gp_frame),
      .gp_trigger      (gp_trigger),
      .frame_interrupt (frame_interrupt),
      .fill_start      (fill_start),
      .fill_frame      (fill_frame),
      .fill_color      (fill_color),
      .fill_done       (fill_done)
   );

   ddr_model ddr_model_i (
      .cpu_clk_g   (cpu_clk_g),
      .rst         (rst),
      .af_wr_en    (af_wr_en),
      .af_op       (af_op),
      .af_addr_din (af_addr_din),
      .wdf_din     (wdf_din),
      .af_full     (af_full),
      .rdf_valid   (rdf_valid),
      .rdf_dout    (rdf_dout)
   );

   initial begin
      cpu_clk_g = 1'b0;
      forever #20 cpu_clk_g = ~cpu_clk_g;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      if (got !== exp) begin
         fail_run($sformatf("CHECK FAILED at %0t: %s, got %0h expected %0h",
                            $time, what, got, exp));
      end
   endtask

   // word address: 6 zero bits, frame, line, beat, 1 zero bit
   function automatic logic [30:0] addr_of(input int frame, input int line, input int beat);
      return {6'b0, 6'(frame), 10'(line), 8'(beat), 1'b0};
   endfunction

   // fill colour in every lane, else lane k holds address + k
   function automatic logic [127:0] expected_word(input int frame, input int line,
                                                  input int beat);
      logic [127:0] word;
      logic [30:0]  addr;
      addr = addr_of(frame, line, beat);
      for (int k = 0; k < 4; k++) begin
         if (filled[frame]) begin
            word[k*32 +: 32] = {8'h00, colour_of[frame]};
         end else begin
            word[k*32 +: 32] = 32'(addr) + 32'(k);
         end
      end
      return word;
   endfunction

   // reference pixel, low 24 bits of the column's lane
   function automatic logic [23:0] ref_pixel(input int frame, input int line, input int col);
      logic [127:0] word;
      word = expected_word(frame, line, col / 4);
      return word[(col % 4)*32 +: 24];
   endfunction

   // display back-pressure, random once enabled
   always @(posedge cpu_clk_g) begin
      #2;
      if (ready_random) begin
         video_ready = ($random(seed) & 1) != 0;
      end else begin
         video_ready = 1'b1;
      end
   end

   // sink and compare, sampled mid-cycle where everything is settled
   always @(negedge cpu_clk_g) begin
      int done_frame;
      if (!rst) begin
         // read data port drained every cycle
         check_equal(rdf_rd_en, 1'b1, "rdf_rd_en held high");
         if (frame_interrupt) begin
            irq_count = irq_count + 1;
            // read-ahead is at most FIFO_BEATS beats
            check_equal(consumed >= irq_count * FRAME_PIX - FIFO_BEATS * 4
                        && consumed <= irq_count * FRAME_PIX, 1,
                        $sformatf("pixels consumed %0d at frame interrupt %0d",
                                  consumed, irq_count));
            if (swap_pend_m) begin
               shown_frame = swap_frame_m;
               swap_pend_m = 1'b0;
            end
            frame_seq.push_back(shown_frame);
         end
         // a trigger counts only from the cycle after it
         if (trig_prev) begin
            swap_pend_m = 1'b1;
         end
         trig_prev = gp_trigger;
         if (gp_trigger) begin
            swap_frame_m = gp_frame;
         end
         if (video_valid && video_ready) begin
            if (frame_seq.size() == 0) begin
               fail_run("a pixel was displayed before any frame was fetched for it");
            end else begin
               check_equal(video, ref_pixel(frame_seq[0], line_pos, col_pos),
                           $sformatf("pixel of frame %0d line %0d col %0d",
                                     frame_seq[0], line_pos, col_pos));
               consumed = consumed + 1;
               if (col_pos == H_PIXELS - 1) begin
                  col_pos = 0;
                  if (line_pos == V_LINES - 1) begin
                     line_pos   = 0;
                     done_frame = frame_seq.pop_front();
                     frames_done = frames_done + 1;
                     if (done_frame == 2) begin
                        frame2_count = frame2_count + 1;
                     end
                  end else begin
                     line_pos = line_pos + 1;
                  end
               end else begin
                  col_pos = col_pos + 1;
               end
            end
         end
      end
   end

   task automatic next_cycle();
      @(posedge cpu_clk_g);
      #2;
   endtask

   task automatic run_until_frames(input int target, input string what);
      int n;
      n = 0;
      while (frames_done < target && n < WAIT_LIMIT) begin
         @(negedge cpu_clk_g);
         n++;
      end
      if (frames_done < target) begin
         fail_run($sformatf("timed out waiting for %s", what));
      end
   endtask

   task automatic wait_fill_done();
      int n;
      n = 0;
      while (!fill_done && n < WAIT_LIMIT) begin
         @(negedge cpu_clk_g);
         n++;
      end
      if (!fill_done) begin
         fail_run("fill engine never signalled fill_done");
      end
   endtask

   // frame 2 all fill colour, frame 1 still the default pattern
   task automatic check_ddr_frames();
      for (int f = 1; f <= 2; f++) begin
         for (int l = 0; l < V_LINES; l++) begin
            for (int b = 0; b < H_PIXELS / 4; b++) begin
               check_equal(ddr_model_i.read_word(addr_of(f, l, b)), expected_word(f, l, b),
                           $sformatf("ddr beat frame %0d line %0d beat %0d", f, l, b));
            end
         end
      end
   endtask

   initial begin
      rst        = 1'b1;
      gp_frame   = '0;
      gp_trigger = 1'b0;
      fill_start = 1'b0;
      fill_frame = '0;
      fill_color = '0;
      video_ready = 1'b1;
      // display starts on frame 1 after reset
      frame_seq.push_back(1);
      repeat (5) @(posedge cpu_clk_g);
      #2;
      rst = 1'b0;

      // frame 1 with the display always ready
      run_until_frames(2, "frame 1 with video_ready high");

      // random display stalls
      ready_random = 1'b1;
      run_until_frames(4, "frame 1 under display back-pressure");

      // clear frame 2 while frame 1 streams
      next_cycle();
      fill_frame      = 6'd2;
      fill_color      = FILL_COLOR;
      fill_start      = 1'b1;
      filled[2]       = 1'b1;
      colour_of[2]    = FILL_COLOR;
      next_cycle();
      fill_start      = 1'b0;
      wait_fill_done();
      check_ddr_frames();
      run_until_frames(frames_done + 1, "display progress after the fill");

      // swap the display to frame 2
      next_cycle();
      gp_frame   = 6'd2;
      gp_trigger = 1'b1;
      next_cycle();
      gp_trigger = 1'b0;
      run_until_frames(frames_done + 4, "frames after the swap request");
      check_equal(frame2_count >= 2, 1, "frames of frame 2 displayed after swap");
      // read-ahead is shorter than a frame, so one interrupt per finished frame
      check_equal(irq_count, frames_done, "frame interrupts per displayed frame");

      $display("Everything OK");
      $finish;
   end

endmodule

// File: flist.f
src/video_pkg.sv
src/pixel_fifo.sv
src/pixel_feeder.sv
src/fill_engine.sv
src/frame_mem_arbiter.sv
src/video_subsystem.sv
testbench/ddr_model.sv
testbench/tb_video_subsystem.sv

// File: Bender.yml
package:
  name: video_subsystem

sources:
  - files:
      - src/video_pkg.sv
      - src/pixel_fifo.sv
      - src/pixel_feeder.sv
      - src/fill_engine.sv
      - src/frame_mem_arbiter.sv
      - src/video_subsystem.sv
  - target: test
    files:
      - testbench/ddr_model.sv
      - testbench/tb_video_subsystem.sv
